// File: src/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// ----------------------------------------------------------------------
	// CSR bus geometry
	// ----------------------------------------------------------------------
	// Word data, shared with the AXI4-Lite side
	localparam int CSR_DATA_W = 32;
	// Register offset inside one bank
	localparam int CSR_REG_W = 2;
	// Bank number, upper part of the word address
	localparam int CSR_BANK_W = 4;
	localparam int CSR_ADDR_W = CSR_BANK_W + CSR_REG_W;
	// Host side uses byte addresses
	localparam int AXIL_ADDR_W = CSR_ADDR_W + 2;

	// Interrupt controller sits in the top bank, timers start at bank 0
	localparam logic [CSR_BANK_W-1:0] IRQ_BANK = CSR_BANK_W'(15);

	// Timer registers, ctrl bit 0 enable, bit 1 auto-reload
	localparam logic [CSR_REG_W-1:0] TMR_REG_CTRL    = CSR_REG_W'(0);
	localparam logic [CSR_REG_W-1:0] TMR_REG_COMPARE = CSR_REG_W'(1);
	localparam logic [CSR_REG_W-1:0] TMR_REG_COUNTER = CSR_REG_W'(2);

	// Interrupt controller registers, pending is write-one-to-clear
	localparam logic [CSR_REG_W-1:0] IRQ_REG_PENDING = CSR_REG_W'(0);
	localparam logic [CSR_REG_W-1:0] IRQ_REG_MASK    = CSR_REG_W'(1);

	// ----------------------------------------------------------------------
	// Bus bundles
	// ----------------------------------------------------------------------
	// CSR request, broadcast to every slave
	typedef struct packed {
		logic [CSR_ADDR_W-1:0] addr;
		logic                  we;
		logic [CSR_DATA_W-1:0] wdata;
	} csr_req_t;

	// Host driven AXI4-Lite signals
	typedef struct packed {
		logic                   awvalid;
		logic [AXIL_ADDR_W-1:0] awaddr;
		logic                   wvalid;
		logic [CSR_DATA_W-1:0]  wdata;
		logic                   bready;
		logic                   arvalid;
		logic [AXIL_ADDR_W-1:0] araddr;
		logic                   rready;
	} axil_req_t;

	// Slave driven AXI4-Lite signals
	typedef struct packed {
		logic                  awready;
		logic                  wready;
		logic                  bvalid;
		logic [1:0]            bresp;
		logic                  arready;
		logic                  rvalid;
		logic [CSR_DATA_W-1:0] rdata;
		logic [1:0]            rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire

// File: src/reset_ctrl.sv
`default_nettype none

module reset_ctrl #(
	parameter int RST_CYCLES        = 64,
	parameter int PERIPH_RST_CYCLES = 16
) (
	input  logic sys_clk,
	input  logic trigger_reset,
	output logic sys_rst_o,
	output logic periph_rst_n_o
);

	// Both counters fit the longer stretch
	localparam int CNT_W = $clog2(RST_CYCLES + 1);

	logic [CNT_W-1:0] rst_cnt;
	logic [CNT_W-1:0] periph_cnt;

	// ----------------------------------------------------------------------
	// Internal reset stretch
	// ----------------------------------------------------------------------
	// Reloads on every trigger cycle, then runs down to zero
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			rst_cnt <= CNT_W'(RST_CYCLES);
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - CNT_W'(1);
		end
	end

	assign sys_rst_o = (rst_cnt != '0);

	// ----------------------------------------------------------------------
	// Peripheral reset release
	// ----------------------------------------------------------------------
	// Counts up from the end of the trigger, saturates at the release point
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			periph_cnt <= '0;
		end else if (periph_cnt != CNT_W'(PERIPH_RST_CYCLES)) begin
			periph_cnt <= periph_cnt + CNT_W'(1);
		end
	end

	// Peripheral comes out first, so it is ready before the bus opens
	assign periph_rst_n_o = (periph_cnt == CNT_W'(PERIPH_RST_CYCLES));

	// Peripheral must never be held in reset once the system runs
	a_periph_before_sys: assert property (
		@(posedge sys_clk) disable iff (trigger_reset)
		!sys_rst_o |-> periph_rst_n_o
	) else $error("peripheral reset still active after system reset release");

endmodule

`default_nettype wire

// File: src/axil_csr_bridge.sv
`default_nettype none

module axil_csr_bridge #(
	parameter int NUM_TIMERS = 4
) (
	input  logic                                           sys_clk,
	input  logic                                           sys_rst_i,
	input  soc_pkg::axil_req_t                             axil_req_i,
	output soc_pkg::axil_rsp_t                             axil_rsp_o,
	output soc_pkg::csr_req_t                              csr_req_o,
	input  logic [NUM_TIMERS:0][soc_pkg::CSR_DATA_W-1:0] csr_rdata_i
);

	localparam int DW = soc_pkg::CSR_DATA_W;
	localparam int AW = soc_pkg::AXIL_ADDR_W;

	// One CSR cycle, one capture cycle, then wait for the host
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CSR,
		ST_CAPTURE,
		ST_RESP
	} state_t;

	state_t state;

	// Opens the host side one cycle after reset
	logic bus_en;
	logic is_wr;
	logic csr_we;
	logic [soc_pkg::CSR_ADDR_W-1:0] csr_addr;
	logic [DW-1:0] csr_wdata;
	logic bvalid_q;
	logic rvalid_q;
	logic [DW-1:0] rdata_q;
	logic [DW-1:0] rd_or;
	logic arready;
	logic wr_ready;
	logic rd_acc;
	logic wr_acc;
	logic rsp_done;

	// ----------------------------------------------------------------------
	// Handshakes
	// ----------------------------------------------------------------------
	assign arready = bus_en && (state == ST_IDLE);
	// Write waits for both channels, reads win a tie
	assign wr_ready = arready && axil_req_i.awvalid && axil_req_i.wvalid &&
		!axil_req_i.arvalid;
	assign rd_acc = arready && axil_req_i.arvalid;
	assign wr_acc = wr_ready;
	assign rsp_done = (bvalid_q && axil_req_i.bready) || (rvalid_q && axil_req_i.rready);

	// OR of all slave read words, idle slaves drive zero
	always_comb begin
		rd_or = '0;
		for (int i = 0; i <= NUM_TIMERS; i++) begin
			rd_or = rd_or | csr_rdata_i[i];
		end
	end

	// ----------------------------------------------------------------------
	// Control FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= ST_IDLE;
			bus_en   <= 1'b0;
			is_wr    <= 1'b0;
			csr_we   <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			bus_en <= 1'b1;
			// Write strobe lasts the single CSR cycle
			csr_we <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rd_acc) begin
						state <= ST_CSR;
						is_wr <= 1'b0;
					end else if (wr_acc) begin
						state  <= ST_CSR;
						is_wr  <= 1'b1;
						csr_we <= 1'b1;
					end
				end
				// Slaves sample the request here
				ST_CSR: state <= ST_CAPTURE;
				// Slave read data is registered now
				ST_CAPTURE: begin
					state    <= ST_RESP;
					bvalid_q <= is_wr;
					rvalid_q <= !is_wr;
				end
				ST_RESP: begin
					if (rsp_done) begin
						state    <= ST_IDLE;
						bvalid_q <= 1'b0;
						rvalid_q <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Address, write data and read data
	// ----------------------------------------------------------------------
	// Byte address to word address, low two bits dropped
	always_ff @(posedge sys_clk) begin
		if (rd_acc) begin
			csr_addr <= axil_req_i.araddr[AW-1:2];
		end else if (wr_acc) begin
			csr_addr  <= axil_req_i.awaddr[AW-1:2];
			csr_wdata <= axil_req_i.wdata;
		end
		// Held until the host takes it
		if ((state == ST_CAPTURE) && !is_wr) begin
			rdata_q <= rd_or;
		end
	end

	assign csr_req_o.addr  = csr_addr;
	assign csr_req_o.we    = csr_we;
	assign csr_req_o.wdata = csr_wdata;

	// Responses are always OKAY
	assign axil_rsp_o.awready = wr_ready;
	assign axil_rsp_o.wready  = wr_ready;
	assign axil_rsp_o.bvalid  = bvalid_q;
	assign axil_rsp_o.bresp   = 2'b00;
	assign axil_rsp_o.arready = arready;
	assign axil_rsp_o.rvalid  = rvalid_q;
	assign axil_rsp_o.rdata   = rdata_q;
	assign axil_rsp_o.rresp   = 2'b00;

	// Only one response at a time
	a_one_rsp: assert property (
		@(posedge sys_clk) disable iff (sys_rst_i)
		!(axil_rsp_o.bvalid && axil_rsp_o.rvalid)
	) else $error("write and read response valid together");

	// Stalled read keeps its data
	a_rdata_stable: assert property (
		@(posedge sys_clk) disable iff (sys_rst_i)
		axil_rsp_o.rvalid && !axil_req_i.rready |=>
			axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata)
	) else $error("read data changed while waiting for rready");

endmodule

`default_nettype wire

// File: src/csr_timer.sv
`default_nettype none

module csr_timer #(
	parameter int BANK_ID = 0
) (
	input  logic                           sys_clk,
	input  logic                           sys_rst_i,
	input  soc_pkg::csr_req_t              csr_req_i,
	output logic [soc_pkg::CSR_DATA_W-1:0] csr_rdata_o,
	output logic                           irq_o
);

	localparam int DW = soc_pkg::CSR_DATA_W;
	localparam int RW = soc_pkg::CSR_REG_W;

	logic ctrl_en;
	logic ctrl_ar;
	logic [DW-1:0] compare;
	logic [DW-1:0] counter;
	logic bank_sel;
	logic csr_wr;
	logic [RW-1:0] reg_sel;
	logic hit;
	logic [DW-1:0] rd_val;

	// ----------------------------------------------------------------------
	// Bank decode
	// ----------------------------------------------------------------------
	assign bank_sel = (csr_req_i.addr[soc_pkg::CSR_ADDR_W-1:RW] ==
		BANK_ID[soc_pkg::CSR_BANK_W-1:0]);
	assign reg_sel = csr_req_i.addr[RW-1:0];
	assign csr_wr = csr_req_i.we && bank_sel;

	// Match while running
	assign hit = ctrl_en && (counter == compare);
	assign irq_o = hit;

	// ----------------------------------------------------------------------
	// Counter and registers
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			ctrl_en <= 1'b0;
			ctrl_ar <= 1'b0;
			compare <= '0;
			counter <= '0;
		end else begin
			if (hit) begin
				// Auto-reload restarts, one-shot stops and holds the count
				if (ctrl_ar) begin
					counter <= '0;
				end else begin
					ctrl_en <= 1'b0;
				end
			end else if (ctrl_en) begin
				counter <= counter + DW'(1);
			end
			// Host write overrides the timer update
			if (csr_wr) begin
				case (reg_sel)
					soc_pkg::TMR_REG_CTRL: begin
						ctrl_en <= csr_req_i.wdata[0];
						ctrl_ar <= csr_req_i.wdata[1];
					end
					soc_pkg::TMR_REG_COMPARE: compare <= csr_req_i.wdata;
					soc_pkg::TMR_REG_COUNTER: counter <= csr_req_i.wdata;
					default: ;
				endcase
			end
		end
	end

	// Read mux, offset 3 is empty
	always_comb begin
		rd_val = '0;
		case (reg_sel)
			soc_pkg::TMR_REG_CTRL:    rd_val[1:0] = {ctrl_ar, ctrl_en};
			soc_pkg::TMR_REG_COMPARE: rd_val = compare;
			soc_pkg::TMR_REG_COUNTER: rd_val = counter;
			default:                  rd_val = '0;
		endcase
	end

	// Zero when not addressed, for the OR on the bridge side
	always_ff @(posedge sys_clk) begin
		csr_rdata_o <= bank_sel ? rd_val : '0;
	end

	// Counter leaves compare after a match unless the host reloads it
	a_irq_pulse: assert property (
		@(posedge sys_clk) disable iff (sys_rst_i)
		irq_o && (compare != '0) && !csr_wr |=> !irq_o
	) else $error("timer interrupt longer than one cycle");

endmodule

`default_nettype wire

// File: src/irq_ctrl.sv
`default_nettype none

module irq_ctrl #(
	parameter int NUM_TIMERS = 4
) (
	input  logic                           sys_clk,
	input  logic                           sys_rst_i,
	input  soc_pkg::csr_req_t              csr_req_i,
	output logic [soc_pkg::CSR_DATA_W-1:0] csr_rdata_o,
	input  logic [NUM_TIMERS-1:0]          irq_pulse_i,
	output logic                           irq_o
);

	localparam int DW = soc_pkg::CSR_DATA_W;
	localparam int RW = soc_pkg::CSR_REG_W;

	logic [NUM_TIMERS-1:0] pending;
	logic [NUM_TIMERS-1:0] mask;
	logic [NUM_TIMERS-1:0] clr;
	logic bank_sel;
	logic csr_wr;
	logic [RW-1:0] reg_sel;
	logic [DW-1:0] rd_val;

	// ----------------------------------------------------------------------
	// Bank decode
	// ----------------------------------------------------------------------
	assign bank_sel = (csr_req_i.addr[soc_pkg::CSR_ADDR_W-1:RW] == soc_pkg::IRQ_BANK);
	assign reg_sel = csr_req_i.addr[RW-1:0];
	assign csr_wr = csr_req_i.we && bank_sel;

	// Write one to clear
	assign clr = (csr_wr && (reg_sel == soc_pkg::IRQ_REG_PENDING)) ?
		csr_req_i.wdata[NUM_TIMERS-1:0] : '0;

	// ----------------------------------------------------------------------
	// Pending and mask
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			pending <= '0;
			mask    <= '0;
		end else begin
			// New pulse beats a clear in the same cycle
			pending <= (pending & ~clr) | irq_pulse_i;
			if (csr_wr && (reg_sel == soc_pkg::IRQ_REG_MASK)) begin
				mask <= csr_req_i.wdata[NUM_TIMERS-1:0];
			end
		end
	end

	// Zero extended, upper bits read zero
	always_comb begin
		rd_val = '0;
		case (reg_sel)
			soc_pkg::IRQ_REG_PENDING: rd_val[NUM_TIMERS-1:0] = pending;
			soc_pkg::IRQ_REG_MASK:    rd_val[NUM_TIMERS-1:0] = mask;
			default:                  rd_val = '0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		csr_rdata_o <= bank_sel ? rd_val : '0;
	end

	// Single line to the host
	assign irq_o = |(pending & mask);

endmodule

`default_nettype wire

// File: src/soc_top.sv
`default_nettype none

module soc_top #(
	parameter int NUM_TIMERS        = 4,
	parameter int RST_CYCLES        = 64,
	parameter int PERIPH_RST_CYCLES = 16
) (
	input  logic               sys_clk,
	input  logic               trigger_reset,
	input  soc_pkg::axil_req_t axil_req_i,
	output soc_pkg::axil_rsp_t axil_rsp_o,
	output logic               irq_o,
	output logic               periph_rst_n_o
);

	// ----------------------------------------------------------------------
	// Reset sequencing
	// ----------------------------------------------------------------------
	logic sys_rst;

	reset_ctrl #(
		.RST_CYCLES        (RST_CYCLES),
		.PERIPH_RST_CYCLES (PERIPH_RST_CYCLES)
	) i_reset_ctrl (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.sys_rst_o      (sys_rst),
		.periph_rst_n_o (periph_rst_n_o)
	);

	// ----------------------------------------------------------------------
	// CSR bus
	// ----------------------------------------------------------------------
	soc_pkg::csr_req_t csr_req;
	// Timers in the low slots, interrupt controller in the top one
	logic [NUM_TIMERS:0][soc_pkg::CSR_DATA_W-1:0] csr_rdata;
	logic [NUM_TIMERS-1:0] timer_irq;

	axil_csr_bridge #(
		.NUM_TIMERS (NUM_TIMERS)
	) i_axil_csr_bridge (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst),
		.axil_req_i  (axil_req_i),
		.axil_rsp_o  (axil_rsp_o),
		.csr_req_o   (csr_req),
		.csr_rdata_i (csr_rdata)
	);

	// Timer n answers at bank n
	for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
		csr_timer #(
			.BANK_ID (i)
		) i_csr_timer (
			.sys_clk     (sys_clk),
			.sys_rst_i   (sys_rst),
			.csr_req_i   (csr_req),
			.csr_rdata_o (csr_rdata[i]),
			.irq_o       (timer_irq[i])
		);
	end

	// ----------------------------------------------------------------------
	// Interrupts
	// ----------------------------------------------------------------------
	irq_ctrl #(
		.NUM_TIMERS (NUM_TIMERS)
	) i_irq_ctrl (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst),
		.csr_req_i   (csr_req),
		.csr_rdata_o (csr_rdata[NUM_TIMERS]),
		.irq_pulse_i (timer_irq),
		.irq_o       (irq_o)
	);

endmodule

`default_nettype wire

// File: sim/tb_soc_top.sv
`default_nettype none

module tb_soc_top;

	localparam int NUM_TIMERS        = 4;
	localparam int RST_CYCLES        = 64;
	localparam int PERIPH_RST_CYCLES = 16;
	// Longest single wait in cycles
	localparam int WAIT_LIMIT = 200;
	// No slave lives here
	localparam logic [3:0] FREE_BANK = 4'd9;

	logic sys_clk;
	logic trigger_reset;
	soc_pkg::axil_req_t axil_req;
	soc_pkg::axil_rsp_t axil_rsp;
	logic irq;
	logic periph_rst_n;

	// Register model
	logic [1:0] m_ctrl [NUM_TIMERS];
	logic [31:0] m_cmp [NUM_TIMERS];
	logic [31:0] m_cnt [NUM_TIMERS];
	logic [NUM_TIMERS-1:0] m_pend;
	logic [NUM_TIMERS-1:0] m_mask;

	logic [31:0] lfsr;
	string test_name;
	// Current read for the comparing process
	logic [7:0] rd_addr;
	logic rd_check;
	int reads_checked;

	soc_top #(
		.NUM_TIMERS        (NUM_TIMERS),
		.RST_CYCLES        (RST_CYCLES),
		.PERIPH_RST_CYCLES (PERIPH_RST_CYCLES)
	) i_soc_top (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.axil_req_i     (axil_req),
		.axil_rsp_o     (axil_rsp),
		.irq_o          (irq),
		.periph_rst_n_o (periph_rst_n)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] byte_addr(input logic [3:0] bank, input logic [1:0] rsel);
		return {bank, rsel, 2'b00};
	endfunction

	// Expected read value from the register map
	function automatic logic [31:0] ref_read(input logic [7:0] addr);
		logic [3:0] bank;
		logic [1:0] rsel;
		logic [31:0] v;
		bank = addr[7:4];
		rsel = addr[3:2];
		v = '0;
		if (int'(bank) < NUM_TIMERS) begin
			case (rsel)
				2'd0: v = {30'd0, m_ctrl[bank[1:0]]};
				2'd1: v = m_cmp[bank[1:0]];
				2'd2: v = m_cnt[bank[1:0]];
				default: v = '0;
			endcase
		end else if (bank == 4'd15) begin
			if (rsel == 2'd0) begin
				v = 32'(m_pend);
			end else if (rsel == 2'd1) begin
				v = 32'(m_mask);
			end
		end
		return v;
	endfunction

	// Host write as the register map applies it
	function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
		logic [3:0] bank;
		logic [1:0] rsel;
		bank = addr[7:4];
		rsel = addr[3:2];
		if (int'(bank) < NUM_TIMERS) begin
			case (rsel)
				2'd0: m_ctrl[bank[1:0]] = data[1:0];
				2'd1: m_cmp[bank[1:0]] = data;
				2'd2: m_cnt[bank[1:0]] = data;
				default: ;
			endcase
		end else if (bank == 4'd15) begin
			// Pending is write one to clear
			if (rsel == 2'd0) begin
				m_pend = m_pend & ~data[NUM_TIMERS-1:0];
			end else if (rsel == 2'd1) begin
				m_mask = data[NUM_TIMERS-1:0];
			end
		end
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout: %s", what);
		$display("STATUS: FAIL");
		$fatal(1, "wait timed out");
	endtask

	// ----------------------------------------------------------------------
	// AXI4-Lite host
	// ----------------------------------------------------------------------
	// Sampled a quarter period after the falling edge
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input int stall);
		int n;
		@(negedge sys_clk);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = addr;
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = data;
		n = 0;
		#1;
		while (!(axil_rsp.awready && axil_rsp.wready)) begin
			n++;
			if (n > WAIT_LIMIT) timeout_fail("write address and data never accepted");
			@(negedge sys_clk);
			#1;
		end
		@(negedge sys_clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		model_write(addr, data);
		n = 0;
		#1;
		while (!axil_rsp.bvalid) begin
			n++;
			if (n > WAIT_LIMIT) timeout_fail("write response never came");
			@(negedge sys_clk);
			#1;
		end
		check({test_name, " bresp"}, 32'd0, 32'(axil_rsp.bresp));
		// Response held while a second write waits
		for (int i = 0; i < stall; i++) begin
			@(negedge sys_clk);
			axil_req.awvalid = 1'b1;
			axil_req.wvalid  = 1'b1;
			#1;
			check({test_name, " bvalid held"}, 32'd1, 32'(axil_rsp.bvalid));
			check({test_name, " no accept"}, 32'd0,
				32'({axil_rsp.arready, axil_rsp.awready, axil_rsp.wready}));
		end
		@(negedge sys_clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		axil_req.bready  = 1'b1;
		@(negedge sys_clk);
		axil_req.bready = 1'b0;
		#1;
		check({test_name, " bvalid drop"}, 32'd0, 32'(axil_rsp.bvalid));
	endtask

	task automatic read_reg(input logic [7:0] addr, input int stall, input logic chk,
		output logic [31:0] data);
		int n;
		@(negedge sys_clk);
		rd_addr = addr;
		rd_check = chk;
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr;
		n = 0;
		#1;
		while (!axil_rsp.arready) begin
			n++;
			if (n > WAIT_LIMIT) timeout_fail("read address never accepted");
			@(negedge sys_clk);
			#1;
		end
		@(negedge sys_clk);
		axil_req.arvalid = 1'b0;
		n = 0;
		#1;
		while (!axil_rsp.rvalid) begin
			n++;
			if (n > WAIT_LIMIT) timeout_fail("read data never came");
			@(negedge sys_clk);
			#1;
		end
		data = axil_rsp.rdata;
		check({test_name, " rresp"}, 32'd0, 32'(axil_rsp.rresp));
		// Data frozen while the host stalls and a write waits
		for (int i = 0; i < stall; i++) begin
			@(negedge sys_clk);
			axil_req.awvalid = 1'b1;
			axil_req.wvalid  = 1'b1;
			#1;
			check({test_name, " rvalid held"}, 32'd1, 32'(axil_rsp.rvalid));
			check({test_name, " rdata stable"}, data, axil_rsp.rdata);
			check({test_name, " no accept"}, 32'd0,
				32'({axil_rsp.arready, axil_rsp.awready, axil_rsp.wready}));
		end
		@(negedge sys_clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		axil_req.rready  = 1'b1;
		@(negedge sys_clk);
		axil_req.rready = 1'b0;
		rd_check = 1'b0;
		#1;
		check({test_name, " rvalid drop"}, 32'd0, 32'(axil_rsp.rvalid));
	endtask

	// Every completed read against the model
	always @(posedge sys_clk) begin
		if (rd_check && axil_rsp.rvalid && axil_req.rready) begin
			check(test_name, ref_read(rd_addr), axil_rsp.rdata);
			reads_checked++;
		end
	end

	// ----------------------------------------------------------------------
	// Tests
	// ----------------------------------------------------------------------
	initial begin
		int n;
		int stall;
		logic [31:0] rd;
		logic [31:0] cmp_val;
		logic [1:0] t;
		logic [1:0] u;
		lfsr = 32'he4d5;
		axil_req = '0;
		trigger_reset = 1'b1;
		rd_addr = '0;
		rd_check = 1'b0;
		reads_checked = 0;
		for (int i = 0; i < NUM_TIMERS; i++) begin
			m_ctrl[i] = '0;
			m_cmp[i] = '0;
			m_cnt[i] = '0;
		end
		m_pend = '0;
		m_mask = '0;

		// Reset sequence
		test_name = "reset";
		repeat (10) begin
			@(negedge sys_clk);
			check("reset periph held", 32'd0, 32'(periph_rst_n));
		end
		trigger_reset = 1'b0;
		n = 0;
		#1;
		while (!axil_rsp.arready) begin
			n++;
			if (n > WAIT_LIMIT) timeout_fail("bus never opened after reset");
			@(negedge sys_clk);
			#1;
		end
		check("reset periph first", 32'd1, 32'(periph_rst_n));
		check("reset irq", 32'd0, 32'(irq));
		for (int b = 0; b < NUM_TIMERS; b++) begin
			for (int r = 0; r < 4; r++) begin
				read_reg(byte_addr(4'(b), 2'(r)), 0, 1'b1, rd);
			end
		end
		read_reg(byte_addr(4'd15, 2'd0), 0, 1'b1, rd);
		read_reg(byte_addr(4'd15, 2'd1), 0, 1'b1, rd);

		// Register access with all timers disabled
		test_name = "regs";
		for (int b = 0; b < NUM_TIMERS; b++) begin
			write_reg(byte_addr(4'(b), 2'd1), rand_bits(32), 0);
			write_reg(byte_addr(4'(b), 2'd2), rand_bits(32), 0);
		end
		write_reg(byte_addr(4'd15, 2'd1), rand_bits(NUM_TIMERS), 0);
		write_reg(byte_addr(FREE_BANK, 2'd1), rand_bits(32), 0);
		for (int b = 0; b < NUM_TIMERS; b++) begin
			read_reg(byte_addr(4'(b), 2'd1), 0, 1'b1, rd);
			read_reg(byte_addr(4'(b), 2'd2), 0, 1'b1, rd);
		end
		read_reg(byte_addr(4'd15, 2'd1), 0, 1'b1, rd);
		read_reg(byte_addr(FREE_BANK, 2'd1), 0, 1'b1, rd);

		// One-shot timer through to irq_o
		test_name = "oneshot";
		t = 2'(rand_bits(2));
		cmp_val = 32'd8 + rand_bits(3);
		write_reg(byte_addr(4'd15, 2'd1), 32'd1 << t, 0);
		write_reg(byte_addr({2'b00, t}, 2'd2), 32'd0, 0);
		write_reg(byte_addr({2'b00, t}, 2'd1), cmp_val, 0);
		write_reg(byte_addr({2'b00, t}, 2'd0), 32'd1, 0);
		n = 0;
		while (!irq) begin
			n++;
			if (n > WAIT_LIMIT) timeout_fail("one-shot timer interrupt never raised");
			@(negedge sys_clk);
		end
		// One-shot stops with the counter at compare
		m_pend[t] = 1'b1;
		m_ctrl[t] = 2'b00;
		m_cnt[t] = m_cmp[t];
		read_reg(byte_addr(4'd15, 2'd0), 0, 1'b1, rd);
		read_reg(byte_addr({2'b00, t}, 2'd0), 0, 1'b1, rd);
		read_reg(byte_addr({2'b00, t}, 2'd2), 0, 1'b1, rd);

		// Masked interrupt and pending clear
		test_name = "mask";
		u = t ^ 2'd1;
		write_reg(byte_addr(4'd15, 2'd1), 32'd0, 0);
		check("mask irq low", 32'd0, 32'(irq));
		write_reg(byte_addr({2'b00, u}, 2'd2), 32'd0, 0);
		write_reg(byte_addr({2'b00, u}, 2'd1), 32'd8 + rand_bits(3), 0);
		write_reg(byte_addr({2'b00, u}, 2'd0), 32'd1, 0);
		// Poll pending without the model
		n = 0;
		read_reg(byte_addr(4'd15, 2'd0), 0, 1'b0, rd);
		while (!rd[u]) begin
			check("mask irq low", 32'd0, 32'(irq));
			n++;
			if (n > WAIT_LIMIT) timeout_fail("masked timer never set its pending bit");
			read_reg(byte_addr(4'd15, 2'd0), 0, 1'b0, rd);
		end
		check("mask irq low", 32'd0, 32'(irq));
		m_pend[u] = 1'b1;
		m_ctrl[u] = 2'b00;
		m_cnt[u] = m_cmp[u];
		read_reg(byte_addr(4'd15, 2'd0), 0, 1'b1, rd);
		read_reg(byte_addr({2'b00, u}, 2'd0), 0, 1'b1, rd);
		write_reg(byte_addr(4'd15, 2'd0), 32'd1 << u, 0);
		read_reg(byte_addr(4'd15, 2'd0), 0, 1'b1, rd);

		// Stalled responses
		test_name = "backpressure";
		for (int b = 0; b < NUM_TIMERS; b++) begin
			stall = 1 + int'(rand_bits(3));
			write_reg(byte_addr(4'(b), 2'd1), rand_bits(32), stall);
			stall = 1 + int'(rand_bits(3));
			read_reg(byte_addr(4'(b), 2'd1), stall, 1'b1, rd);
		end

		repeat (4) @(negedge sys_clk);
		if (reads_checked > 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("No read was compared against the model");
			$display("STATUS: FAIL");
			$fatal(1, "no reads checked");
		end
	end

endmodule

`default_nettype wire

// File: flist.f
src/soc_pkg.sv
src/reset_ctrl.sv
src/axil_csr_bridge.sv
src/csr_timer.sv
src/irq_ctrl.sv
src/soc_top.sv
sim/tb_soc_top.sv

// File: Makefile
# Verilator build and run for the CSR subsystem testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_soc_top
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search the output for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
